//--- Makefile
TOP = tb_pll_ctrl

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sources.f
src/pll_ctrl_pkg.sv
src/pll_apb_regs.sv
src/pll_startup_seq.sv
src/pll_test_port.sv
src/pll_ctrl_top.sv
verif/pll_model.sv
verif/tb_pll_ctrl.sv

//--- src/pll_apb_regs.sv
`timescale 1ns/1ps
// PLL APB register block that decodes accesses, holds the dividers and forwards control and test traffic
module pll_apb_regs (
    input  logic                                 ref_clk,
    input  logic                                 resetn,
    input  logic                                 psel,
    input  logic [pll_ctrl_pkg::addr_w-1:0]      paddr,
    input  logic                                 penable,
    input  logic [2:0]                           pprot,
    input  logic [3:0]                           pstrb,
    input  logic                                 pwrite,
    input  logic [pll_ctrl_pkg::data_w-1:0]      pwdata,
    output logic [pll_ctrl_pkg::data_w-1:0]      prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic [3:0]                           divvcop,
    output logic [3:0]                           divvcor,
    output logic [6:0]                           fbdiv,
    output logic [5:0]                           p,
    output logic [5:0]                           r,
    output logic [4:0]                           prediv,
    output logic                                 ctrl_wr,
    output logic [3:0]                           ctrl_wdata,     // {gear, enr, enp, bypass}
    input  logic                                 bypass,
    input  logic                                 enp,
    input  logic                                 enr,
    input  logic                                 gear_shift,
    input  logic [pll_ctrl_pkg::cnt_w-1:0]       gs_count,
    input  logic [pll_ctrl_pkg::cnt_w-1:0]       en_count,
    input  logic                                 lock_status,
    output logic                                 test_start,
    output logic                                 test_write,
    output logic [pll_ctrl_pkg::test_off_w-1:0]  test_offset,
    output logic [pll_ctrl_pkg::test_data_w-1:0] test_wdata,
    input  logic                                 test_done,
    input  logic [pll_ctrl_pkg::test_data_w-1:0] test_rdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_local,
        st_test_wait,
        st_respond
    } state_t;

    state_t                          state;
    logic                            is_test;
    logic                            test_ok;
    logic                            local_ok;
    logic                            local_err;
    logic                            local_wr;
    logic [pll_ctrl_pkg::data_w-1:0] rd_word;

    assign is_test  = paddr[pll_ctrl_pkg::test_space_bit];
    assign test_ok  = is_test && (paddr <= pll_ctrl_pkg::test_addr_max);
    assign local_ok = !is_test && (paddr <= pll_ctrl_pkg::addr_lock);

    // Bad test addresses also land here and fail as undefined
    always_comb begin
        local_err = !local_ok;
        if (pwrite) begin
            if (paddr == pll_ctrl_pkg::addr_gs_cnt || paddr == pll_ctrl_pkg::addr_en_cnt) begin
                local_err = 1'b1;                 // Counters are read only
            end
            if (paddr == pll_ctrl_pkg::addr_ctrl && !pstrb[0]) begin
                local_err = 1'b1;
            end
        end
    end

    assign local_wr = (state == st_local) && pwrite && !local_err;

    // Test port request taken straight from the held APB address phase
    assign test_start  = (state == st_idle) && psel && test_ok;
    assign test_write  = pwrite;
    assign test_offset = paddr[pll_ctrl_pkg::test_off_w-1:0];
    assign test_wdata  = pwdata[pll_ctrl_pkg::test_data_w-1:0];

    always_ff @(posedge ref_clk or negedge resetn) begin
        if (!resetn) begin
            state   <= st_idle;
            pready  <= 1'b0;
            pslverr <= 1'b0;
            ctrl_wr <= 1'b0;
        end else begin
            pready  <= 1'b0;
            ctrl_wr <= 1'b0;
            case (state)
                st_idle: begin
                    if (psel) begin
                        state <= test_ok ? st_test_wait : st_local;
                    end
                end
                st_local: begin
                    pready  <= 1'b1;
                    pslverr <= local_err;
                    ctrl_wr <= local_wr && (paddr == pll_ctrl_pkg::addr_ctrl);
                    state   <= st_respond;
                end
                st_test_wait: begin
                    if (test_done) begin
                        pready  <= 1'b1;
                        pslverr <= 1'b0;
                        state   <= st_respond;
                    end
                end
                default: state <= st_idle;    // Respond cycle with pready up
            endcase
        end
    end

    always_ff @(posedge ref_clk) begin
        if (state == st_local) begin
            prdata <= rd_word;
        end else if (state == st_test_wait && test_done) begin
            prdata <= {{(pll_ctrl_pkg::data_w - pll_ctrl_pkg::test_data_w){1'b0}}, test_rdata};
        end
        if (local_wr && paddr == pll_ctrl_pkg::addr_ctrl) begin
            ctrl_wdata <= {pwdata[pll_ctrl_pkg::ctrl_gear_bit], pwdata[pll_ctrl_pkg::ctrl_enr_bit],
                           pwdata[pll_ctrl_pkg::ctrl_enp_bit], pwdata[pll_ctrl_pkg::ctrl_bypass_bit]};
        end
    end

    // Divider registers with per-byte strobes
    always_ff @(posedge ref_clk or negedge resetn) begin
        if (!resetn) begin
            divvcop <= pll_ctrl_pkg::default_divvcop;
            divvcor <= pll_ctrl_pkg::default_divvcor;
            fbdiv   <= pll_ctrl_pkg::default_fbdiv;
            p       <= pll_ctrl_pkg::default_p;
            r       <= pll_ctrl_pkg::default_r;
            prediv  <= pll_ctrl_pkg::default_prediv;
        end else if (local_wr) begin
            if (paddr == pll_ctrl_pkg::addr_div_pr) begin
                if (pstrb[0]) r       <= pwdata[5:0];
                if (pstrb[1]) divvcor <= pwdata[11:8];
                if (pstrb[2]) p       <= pwdata[21:16];
                if (pstrb[3]) divvcop <= pwdata[27:24];
            end
            if (paddr == pll_ctrl_pkg::addr_div_fb) begin
                if (pstrb[0]) fbdiv  <= pwdata[6:0];
                if (pstrb[1]) prediv <= pwdata[12:8];   // Upper bytes are ignored
            end
        end
    end

    // Read data is zero for anything undefined
    always_comb begin
        rd_word = '0;
        case (paddr)
            pll_ctrl_pkg::addr_ctrl: begin
                rd_word[pll_ctrl_pkg::ctrl_bypass_bit] = bypass;
                rd_word[pll_ctrl_pkg::ctrl_enp_bit]    = enp;
                rd_word[pll_ctrl_pkg::ctrl_enr_bit]    = enr;
                rd_word[pll_ctrl_pkg::ctrl_gear_bit]   = gear_shift;
            end
            pll_ctrl_pkg::addr_gs_cnt: rd_word[pll_ctrl_pkg::cnt_w-1:0] = gs_count;
            pll_ctrl_pkg::addr_en_cnt: rd_word[pll_ctrl_pkg::cnt_w-1:0] = en_count;
            pll_ctrl_pkg::addr_div_pr: rd_word = {4'b0, divvcop, 2'b0, p, 4'b0, divvcor, 2'b0, r};
            pll_ctrl_pkg::addr_div_fb: rd_word = {19'b0, prediv, 1'b0, fbdiv};
            pll_ctrl_pkg::addr_id:     rd_word = pll_ctrl_pkg::id_word;
            pll_ctrl_pkg::addr_lock:   rd_word[0] = lock_status;
            default: ;
        endcase
    end

    // One-cycle ready so a master never sees one response twice
    a_pready_pulse: assert property (@(posedge ref_clk) disable iff (!resetn)
        pready |=> !pready)
        else $error("pready high for two cycles");

endmodule

//--- src/pll_ctrl_pkg.sv
// PLL control package with the register map, field positions, defaults, sequencer limits and test map
package pll_ctrl_pkg;

    // APB bus
    localparam int addr_w = 10;
    localparam int data_w = 32;

    // Local register addresses
    localparam logic [addr_w-1:0] addr_ctrl   = 10'h000;
    localparam logic [addr_w-1:0] addr_gs_cnt = 10'h001;
    localparam logic [addr_w-1:0] addr_en_cnt = 10'h002;
    localparam logic [addr_w-1:0] addr_div_pr = 10'h003;
    localparam logic [addr_w-1:0] addr_div_fb = 10'h004;
    localparam logic [addr_w-1:0] addr_id     = 10'h005;
    localparam logic [addr_w-1:0] addr_lock   = 10'h006;

    // Upper half of the address space goes to the PLL test bus
    localparam int                test_space_bit = 9;
    localparam logic [addr_w-1:0] test_addr_max  = 10'h20C;

    // Control register fields
    localparam int ctrl_bypass_bit = 0;
    localparam int ctrl_enp_bit    = 4;
    localparam int ctrl_enr_bit    = 5;
    localparam int ctrl_gear_bit   = 7;

    // Divider values after reset
    localparam logic [3:0] default_divvcop = 4'h0;
    localparam logic [3:0] default_divvcor = 4'h0;
    localparam logic [6:0] default_fbdiv   = 7'h10; // Feedback x16
    localparam logic [5:0] default_p       = 6'h03;
    localparam logic [5:0] default_r       = 6'h01;
    localparam logic [4:0] default_prediv  = 5'h00;

    localparam logic [data_w-1:0] id_word = 32'h534E_504C; // "SNPL"

    // Startup sequencer
    localparam int               cnt_w         = 16;
    localparam logic [cnt_w-1:0] gear_cycles   = 16'd16000;
    localparam logic [cnt_w-1:0] enable_cycles = 16'd10000;

    // PLL test register bus
    localparam int                    test_sel_w       = 5;
    localparam int                    test_data_w      = 8;
    localparam int                    test_off_w       = 4;
    localparam int                    test_cnt_w       = 3;
    localparam logic [test_cnt_w-1:0] test_wait_cycles = 3'd3;
    localparam int                    test_entries     = 13;

    // Offset from 0x200 to the macro's test select
    localparam logic [test_sel_w-1:0] test_map [test_entries] = '{
        5'h00, 5'h01, 5'h02, 5'h03, 5'h04,       // Core registers
        5'h10, 5'h11, 5'h12, 5'h13,
        5'h14, 5'h15, 5'h16, 5'h17               // Upper bank
    };

endpackage

//--- src/pll_ctrl_top.sv
`timescale 1ns/1ps
// PLL control top level joining the APB register block, startup sequencer and test port
module pll_ctrl_top (
    input  logic                                 ref_clk,
    input  logic                                 resetn,
    // APB
    input  logic                                 psel,
    input  logic [pll_ctrl_pkg::addr_w-1:0]      paddr,
    input  logic                                 penable,
    input  logic [2:0]                           pprot,
    input  logic [3:0]                           pstrb,
    input  logic                                 pwrite,
    input  logic [pll_ctrl_pkg::data_w-1:0]      pwdata,
    output logic [pll_ctrl_pkg::data_w-1:0]      prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    // PLL macro control
    output logic [3:0]                           divvcop,
    output logic [3:0]                           divvcor,
    output logic [6:0]                           fbdiv,
    output logic [5:0]                           p,
    output logic [5:0]                           r,
    output logic [4:0]                           prediv,
    output logic                                 bypass,
    output logic                                 enp,
    output logic                                 enr,
    output logic                                 gear_shift,
    input  logic                                 pll_lock,
    // PLL macro test bus
    output logic [pll_ctrl_pkg::test_sel_w-1:0]  test_sel,
    output logic                                 test_wr_en,
    output logic                                 test_rd_en,
    output logic [pll_ctrl_pkg::test_data_w-1:0] test_data_in,
    input  logic [pll_ctrl_pkg::test_data_w-1:0] test_data_out
);

    // Register block to sequencer
    logic                                 ctrl_wr;
    logic [3:0]                           ctrl_wdata;
    logic [pll_ctrl_pkg::cnt_w-1:0]       gs_count;
    logic [pll_ctrl_pkg::cnt_w-1:0]       en_count;
    logic                                 lock_status;

    // Register block to test port
    logic                                 test_start;
    logic                                 test_write;
    logic [pll_ctrl_pkg::test_off_w-1:0]  test_offset;
    logic [pll_ctrl_pkg::test_data_w-1:0] test_wdata;
    logic                                 test_done;
    logic [pll_ctrl_pkg::test_data_w-1:0] test_rdata;

    // Port names match the nets above one to one
    pll_apb_regs pll_apb_regs_inst (.*);

    pll_startup_seq pll_startup_seq_inst (.*);

    pll_test_port pll_test_port_inst (.*);

endmodule

//--- src/pll_startup_seq.sv
`timescale 1ns/1ps
// PLL startup sequencer that runs gear shift, then output enables, and captures lock
module pll_startup_seq (
    input  logic                           ref_clk,
    input  logic                           resetn,
    input  logic                           ctrl_wr,
    input  logic [3:0]                     ctrl_wdata,  // {gear, enr, enp, bypass}
    input  logic                           pll_lock,
    output logic                           bypass,
    output logic                           enp,
    output logic                           enr,
    output logic                           gear_shift,
    output logic [pll_ctrl_pkg::cnt_w-1:0] gs_count,
    output logic [pll_ctrl_pkg::cnt_w-1:0] en_count,
    output logic                           lock_status
);

    logic gs_done;
    logic en_done;
    logic en_wait;

    assign gs_done = (gs_count == pll_ctrl_pkg::gear_cycles);
    assign en_done = (en_count == pll_ctrl_pkg::enable_cycles);
    assign en_wait = !gear_shift && !(enp && enr);  // Gear released and outputs not both on

    // Counters stop at their limits and keep the value for readback
    always_ff @(posedge ref_clk or negedge resetn) begin
        if (!resetn) begin
            gs_count <= '0;
            en_count <= '0;
        end else begin
            if (gear_shift && !gs_done) begin
                gs_count <= gs_count + 1'b1;
            end
            if (en_wait && !en_done) begin
                en_count <= en_count + 1'b1;
            end
        end
    end

    // A register write wins over the automatic sequence
    always_ff @(posedge ref_clk or negedge resetn) begin
        if (!resetn) begin
            bypass     <= 1'b0;
            enp        <= 1'b0;
            enr        <= 1'b0;
            gear_shift <= 1'b1;         // Fast locking right after reset
        end else if (ctrl_wr) begin
            bypass     <= ctrl_wdata[0];
            enp        <= ctrl_wdata[1];
            enr        <= ctrl_wdata[2];
            gear_shift <= ctrl_wdata[3];
        end else if (gear_shift && gs_done) begin
            gear_shift <= 1'b0;
        end else if (en_wait && en_done) begin
            enp <= 1'b1;
            enr <= 1'b1;
        end
    end

    // Lock is only meaningful with an output running
    always_ff @(posedge ref_clk or negedge resetn) begin
        if (!resetn) begin
            lock_status <= 1'b0;
        end else if (enp || enr) begin
            lock_status <= pll_lock;
        end
    end

    // Enables follow gear release unless software forces them
    a_enp_after_gear: assert property (@(posedge ref_clk) disable iff (!resetn)
        (!enp && gear_shift && !ctrl_wr) |=> !enp)
        else $error("enp rose while gear_shift was high");

endmodule

//--- src/pll_test_port.sv
`timescale 1ns/1ps
// PLL test port bridge that maps test offsets to selects and times the slow test bus access
module pll_test_port (
    input  logic                                 ref_clk,
    input  logic                                 resetn,
    input  logic                                 test_start,
    input  logic                                 test_write,
    input  logic [pll_ctrl_pkg::test_off_w-1:0]  test_offset,
    input  logic [pll_ctrl_pkg::test_data_w-1:0] test_wdata,
    input  logic [pll_ctrl_pkg::test_data_w-1:0] test_data_out,
    output logic                                 test_done,
    output logic [pll_ctrl_pkg::test_data_w-1:0] test_rdata,
    output logic [pll_ctrl_pkg::test_sel_w-1:0]  test_sel,
    output logic                                 test_wr_en,
    output logic                                 test_rd_en,
    output logic [pll_ctrl_pkg::test_data_w-1:0] test_data_in
);

    logic [pll_ctrl_pkg::test_cnt_w-1:0] wait_cnt;
    logic                                busy;

    assign busy = test_wr_en || test_rd_en;

    // Last cycle of the enable window
    assign test_done = busy && (wait_cnt == pll_ctrl_pkg::test_wait_cycles);

    always_ff @(posedge ref_clk or negedge resetn) begin
        if (!resetn) begin
            test_wr_en <= 1'b0;
            test_rd_en <= 1'b0;
            wait_cnt   <= '0;
        end else if (test_start) begin
            test_wr_en <= test_write;
            test_rd_en <= !test_write;
            wait_cnt   <= '0;
        end else if (test_done) begin
            test_wr_en <= 1'b0;
            test_rd_en <= 1'b0;
            wait_cnt   <= '0;
        end else if (busy) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // Select and data stay stable for the whole access
    always_ff @(posedge ref_clk) begin
        if (test_start) begin
            if (test_offset < pll_ctrl_pkg::test_entries) begin
                test_sel <= pll_ctrl_pkg::test_map[test_offset];
            end else begin
                test_sel <= '0;
            end
            test_data_in <= test_wdata;
        end
        if (test_rd_en) begin
            test_rdata <= test_data_out;   // Macro output has settled by the done cycle
        end
    end

    a_single_enable: assert property (@(posedge ref_clk) disable iff (!resetn)
        !(test_wr_en && test_rd_en))
        else $error("test write and read enables both high");

endmodule

//--- verif/pll_model.sv
`timescale 1ns/1ps
// Behavioral PLL macro stand-in with a lock timer and a 32-entry test register bank
module pll_model (
    input  logic       ref_clk,
    input  logic       resetn,
    input  logic       enp,
    input  logic       enr,
    input  logic [4:0] test_sel,
    input  logic       test_wr_en,
    input  logic       test_rd_en,
    input  logic [7:0] test_data_in,
    output logic       pll_lock,
    output logic [7:0] test_data_out,
    output logic [4:0] last_sel,       // Select of the latest test access
    output int         access_count    // Test accesses started since reset
);

    localparam int lock_delay = 64;    // Cycles with both enables up before lock

    logic [7:0] bank [32];
    logic       busy_q;
    int         lock_cnt;

    assign test_data_out = test_rd_en ? bank[test_sel] : 8'h00;

    // The loop keeps running when the outputs are gated, so lock stays once reached
    always @(posedge ref_clk or negedge resetn) begin
        if (!resetn) begin
            pll_lock <= 1'b0;
            lock_cnt <= 0;
        end else if (!pll_lock) begin
            if (!(enp && enr)) begin
                lock_cnt <= 0;
            end else if (lock_cnt == lock_delay - 1) begin
                pll_lock <= 1'b1;
            end else begin
                lock_cnt <= lock_cnt + 1;
            end
        end
    end

    // Each entry starts from a value built from its whole select
    always @(posedge ref_clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < 32; i++) begin
                bank[i] <= 8'(i * 37) ^ 8'h5a;
            end
            busy_q       <= 1'b0;
            last_sel     <= '0;
            access_count <= 0;
        end else begin
            busy_q <= test_wr_en || test_rd_en;
            if (test_wr_en || test_rd_en) begin
                last_sel <= test_sel;
            end
            if ((test_wr_en || test_rd_en) && !busy_q) begin
                access_count <= access_count + 1;   // Rising edge of an enable
            end
            if (test_wr_en) begin
                bank[test_sel] <= test_data_in;
            end
        end
    end

endmodule

//--- verif/tb_pll_ctrl.sv
`timescale 1ns/1ps
// PLL control testbench with APB tasks, a register and sequencer model and six tests
module tb_pll_ctrl;

    localparam int planned_xfers = 500;
    localparam int cycle_limit   = int'(pll_ctrl_pkg::gear_cycles)
                                   + int'(pll_ctrl_pkg::enable_cycles)
                                   + 200 * planned_xfers + 5000;
    localparam int max_polls     = 2000;

    logic        ref_clk;
    logic        resetn;
    logic        psel;
    logic [9:0]  paddr;
    logic        penable;
    logic [2:0]  pprot;
    logic [3:0]  pstrb;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [3:0]  divvcop;
    logic [3:0]  divvcor;
    logic [6:0]  fbdiv;
    logic [5:0]  p;
    logic [5:0]  r;
    logic [4:0]  prediv;
    logic        bypass;
    logic        enp;
    logic        enr;
    logic        gear_shift;
    logic        pll_lock;
    logic [4:0]  test_sel;
    logic        test_wr_en;
    logic        test_rd_en;
    logic [7:0]  test_data_in;
    logic [7:0]  test_data_out;
    logic [4:0]  last_sel;
    int          access_count;

    int          errors;
    int          checks;
    int          test_err;
    int          off;
    int          polls;
    int          acc_before;
    bit          seq_bad;
    logic [31:0] m_pr;             // Model of the P/R divider word
    logic [31:0] m_fb;             // Model of the FB divider word
    logic [7:0]  m_bank [32];      // Model test bank by select
    logic [31:0] rdata;
    logic [31:0] word;
    logic [3:0]  strb;
    logic [9:0]  addr_pick;
    logic        err;

    pll_ctrl_top pll_ctrl_top_inst (.*);

    pll_model pll_model_inst (.*);

    initial begin
        ref_clk = 1'b0;
        forever #20 ref_clk = ~ref_clk;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge ref_clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycles);
        $display("Done: errors found");
        $finish;
    end

    // Enables must not come up while gear shift still holds
    always @(negedge ref_clk) begin
        if (resetn && !seq_bad) begin
            assert (!(gear_shift && (enp || enr))) else begin
                errors++;
                seq_bad = 1'b1;
                $display("output enables came up at %0t while gear shift was still high", $time);
            end
        end
    end

    function automatic logic [31:0] byte_mask(input logic [3:0] s);
        return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    // Offsets 0 to 4 keep their number and 5 to 12 land in the upper bank at 0x10
    function automatic logic [4:0] expected_sel(input int o);
        return (o < 5) ? 5'(o) : 5'(o + 11);
    endfunction

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic expect_event(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("%s", msg);
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [9:0] addr, input logic [31:0] wdata,
                            input logic [3:0] s, output logic [31:0] rd, output logic slverr);
        int waited;
        waited = 0;
        @(posedge ref_clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        pstrb   <= s;
        @(posedge ref_clk);
        penable <= 1'b1;
        @(negedge ref_clk);
        while (!pready && waited < 200) begin
            @(negedge ref_clk);
            waited++;
        end
        expect_event(pready, $sformatf("no pready from the DUT for the access to 0x%03h", addr));
        rd     = prdata;
        slverr = pslverr;
        @(posedge ref_clk);
        psel    <= 1'b0;             // Released in the cycle after pready
        penable <= 1'b0;
    endtask

    task automatic read_check(input logic [9:0] addr, input logic [31:0] exp, input logic exp_err,
                              input string what);
        logic [31:0] rd;
        logic        slverr;
        apb_xfer(1'b0, addr, 32'h0, 4'h0, rd, slverr);
        check_value(what, rd, exp);
        check_value({what, " pslverr"}, 32'(slverr), 32'(exp_err));
    endtask

    task automatic write_reg(input logic [9:0] addr, input logic [31:0] data, input logic [3:0] s,
                             input logic exp_err);
        logic [31:0] rd;
        logic        slverr;
        apb_xfer(1'b1, addr, data, s, rd, slverr);
        check_value($sformatf("pslverr on write to 0x%03h", addr), 32'(slverr), 32'(exp_err));
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %s, %0d errors", num, name,
                 (errors == test_err) ? "passed" : "failed", errors - test_err);
        test_err = errors;
    endtask

    initial begin
        void'($urandom(32'hd7ef_5ec1));
        errors   = 0;
        checks   = 0;
        test_err = 0;
        seq_bad  = 1'b0;
        resetn   = 1'b0;
        psel     = 1'b0;
        paddr    = '0;
        penable  = 1'b0;
        pprot    = 3'b000;
        pstrb    = 4'h0;
        pwrite   = 1'b0;
        pwdata   = '0;
        repeat (4) @(posedge ref_clk);
        resetn <= 1'b1;

        // P/R register layout is {divvcop, p, divvcor, r} on byte lanes 3 to 0
        m_pr = (32'(pll_ctrl_pkg::default_divvcop) << 24) | (32'(pll_ctrl_pkg::default_p) << 16)
             | (32'(pll_ctrl_pkg::default_divvcor) << 8) | 32'(pll_ctrl_pkg::default_r);
        m_fb = (32'(pll_ctrl_pkg::default_prediv) << 8) | 32'(pll_ctrl_pkg::default_fbdiv);
        read_check(pll_ctrl_pkg::addr_id, pll_ctrl_pkg::id_word, 1'b0, "identity");
        read_check(pll_ctrl_pkg::addr_ctrl, 32'h80, 1'b0, "control");    // Gear shift only
        read_check(pll_ctrl_pkg::addr_div_pr, m_pr, 1'b0, "P/R dividers");
        read_check(pll_ctrl_pkg::addr_div_fb, m_fb, 1'b0, "FB dividers");
        read_check(pll_ctrl_pkg::addr_lock, 32'h0, 1'b0, "lock status");
        check_value("gear_shift pin", 32'(gear_shift), 32'h1);
        end_test(1, "reset defaults");

        for (int i = 0; i < 200; i++) begin
            word      = $urandom;
            strb      = 4'($urandom);
            addr_pick = ($urandom % 2) ? pll_ctrl_pkg::addr_div_fb : pll_ctrl_pkg::addr_div_pr;
            write_reg(addr_pick, word, strb, 1'b0);
            if (addr_pick == pll_ctrl_pkg::addr_div_pr) begin
                m_pr = (m_pr & ~byte_mask(strb)) | (word & byte_mask(strb) & 32'h0F3F_0F3F);
            end else begin
                m_fb = (m_fb & ~byte_mask(strb)) | (word & byte_mask(strb) & 32'h0000_1F7F);
            end
            read_check(addr_pick, (addr_pick == pll_ctrl_pkg::addr_div_pr) ? m_pr : m_fb, 1'b0,
                       "divider readback");
            check_value("P/R pins", {divvcop, p, divvcor, r},
                        {m_pr[27:24], m_pr[21:16], m_pr[11:8], m_pr[5:0]});
            check_value("FB pins", {prediv, fbdiv}, {m_fb[12:8], m_fb[6:0]});
        end
        end_test(2, "divider writes");

        acc_before = access_count;
        write_reg(pll_ctrl_pkg::addr_gs_cnt, $urandom, 4'hF, 1'b1);
        write_reg(pll_ctrl_pkg::addr_en_cnt, $urandom, 4'hF, 1'b1);
        write_reg(pll_ctrl_pkg::addr_ctrl, 32'h0000_00B1, {3'($urandom), 1'b0}, 1'b1);
        write_reg(10'h007 + 10'($urandom % 32'h1F9), $urandom, 4'hF, 1'b1);
        write_reg(10'h20D + 10'($urandom % 32'h1F3), $urandom, 4'hF, 1'b1);  // Past the test map
        read_check(10'h007, 32'h0, 1'b1, "undefined local read");
        read_check(10'h3FF, 32'h0, 1'b1, "undefined test read");
        check_value("test accesses after bad addresses", access_count, acc_before);
        // Still well inside the gear-shift hold time
        read_check(pll_ctrl_pkg::addr_ctrl, 32'h80, 1'b0, "control after errors");
        read_check(pll_ctrl_pkg::addr_div_pr, m_pr, 1'b0, "P/R after errors");
        read_check(pll_ctrl_pkg::addr_div_fb, m_fb, 1'b0, "FB after errors");
        end_test(3, "error responses");

        read_check(pll_ctrl_pkg::addr_ctrl, 32'h80, 1'b0, "control before release");
        apb_xfer(1'b0, pll_ctrl_pkg::addr_gs_cnt, 32'h0, 4'h0, word, err);
        repeat (20) @(posedge ref_clk);
        apb_xfer(1'b0, pll_ctrl_pkg::addr_gs_cnt, 32'h0, 4'h0, rdata, err);
        check_value("gear counter rising", 32'(rdata > word), 32'h1);
        polls = 0;
        rdata = 32'h80;
        while (rdata[7] && polls < max_polls) begin
            repeat (20) @(posedge ref_clk);
            apb_xfer(1'b0, pll_ctrl_pkg::addr_ctrl, 32'h0, 4'h0, rdata, err);
            polls++;
        end
        expect_event(!rdata[7], "gear shift was never released");
        read_check(pll_ctrl_pkg::addr_gs_cnt, 32'(pll_ctrl_pkg::gear_cycles), 1'b0, "gear counter");
        while (rdata[5:4] != 2'b11 && polls < max_polls) begin
            repeat (20) @(posedge ref_clk);
            apb_xfer(1'b0, pll_ctrl_pkg::addr_ctrl, 32'h0, 4'h0, rdata, err);
            polls++;
        end
        expect_event(rdata[5:4] == 2'b11, "the output enables never came up");
        check_value("control after enables", rdata, 32'h30);
        check_value("enable pins", 32'({enp, enr}), 32'h3);
        repeat (50) @(posedge ref_clk);
        read_check(pll_ctrl_pkg::addr_en_cnt, 32'(pll_ctrl_pkg::enable_cycles), 1'b0,
                   "enable counter held");
        end_test(4, "startup sequence");

        for (int i = 0; i < 33; i++) begin
            off  = (i < 13) ? i : int'($urandom % 13);    // Every offset once and then random
            word = $urandom;
            write_reg(10'h200 + 10'(off), word, 4'hF, 1'b0);
            m_bank[expected_sel(off)] = word[7:0];
            check_value("select on test write", 32'(last_sel), 32'(expected_sel(off)));
        end
        for (int i = 0; i < 20; i++) begin
            off = int'($urandom % 13);
            read_check(10'h200 + 10'(off), 32'(m_bank[expected_sel(off)]), 1'b0, "test register");
            check_value("select on test read", 32'(last_sel), 32'(expected_sel(off)));
        end
        end_test(5, "test port");

        polls = 0;
        rdata = 32'h0;
        while (!rdata[0] && polls < max_polls) begin
            repeat (10) @(posedge ref_clk);
            apb_xfer(1'b0, pll_ctrl_pkg::addr_lock, 32'h0, 4'h0, rdata, err);
            polls++;
        end
        expect_event(rdata[0], "lock status never read 1");
        check_value("pll_lock pin", 32'(pll_lock), 32'h1);
        // Both enables cleared with bypass switched on
        write_reg(pll_ctrl_pkg::addr_ctrl, 32'h1, 4'hF, 1'b0);
        read_check(pll_ctrl_pkg::addr_lock, 32'h1, 1'b0, "lock after enables cleared");
        // Enable counter sits at its limit, so the outputs come straight back
        read_check(pll_ctrl_pkg::addr_ctrl, 32'h31, 1'b0, "control after enables cleared");
        check_value("bypass pin", 32'(bypass), 32'h1);
        end_test(6, "lock status");

        $display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
